// ==== common/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define XLEN 32
`define IM_AW 10
`define DM_AW 12

// major opcodes, instruction bits 30:25
`define OP_ALU  6'b100000
`define OP_ADDI 6'b101000
`define OP_ORI  6'b101100
`define OP_MOVI 6'b100010
`define OP_LWI  6'b000010
`define OP_SWI  6'b001010
`define OP_BR   6'b100110
`define OP_J    6'b100100

// sub-op codes of OP_ALU, bits 4:0
`define SUB_ADD 5'b00000
`define SUB_SUB 5'b00001
`define SUB_AND 5'b00010
`define SUB_OR  5'b00100
`define SUB_XOR 5'b00011

`endif

// ==== common/cpu_pkg.sv ====
`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [`IM_AW-1:0] pc_t;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		PASS_B
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_e;

	// all-zero bundle is a no-op
	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm;
		logic reg_write;
		logic mem_read;
		logic mem_write;
		wb_sel_e wb_sel;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t a;
		word_t b;
		word_t st_data;
		reg_addr_t rd;
	} ex_pay_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t st_data;
		reg_addr_t rd;
	} mem_pay_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t rd;
		word_t data;
	} wb_pay_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input alu_op_e op,
	input word_t a,
	input word_t b,
	output word_t result,
	output logic overflow
);

	word_t sum;
	word_t diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		result = sum;
		overflow = 1'b0;
		case (op)
			ADD: begin
				result = sum;
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			SUB: begin
				result = diff;
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			// movi
			PASS_B: result = b;
			default: result = sum;
		endcase
	end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input instr_t instruction,
	output pc_t IM_address,
	output logic DM_read,
	output logic DM_write,
	output logic [`DM_AW-1:0] DM_address,
	output word_t DM_in,
	input word_t DM_out,
	output logic alu_overflow
);

	pc_t if_pc;
	pc_t id_pc;
	pc_t br_target;
	instr_t id_instr;
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rt_addr;
	word_t raw_ra;
	word_t raw_rb;
	word_t raw_rt;
	word_t fwd_ra;
	word_t fwd_rb;
	word_t fwd_rt;
	word_t op_b;
	ctrl_t id_ctrl;
	logic taken;
	logic hazard;
	ex_pay_t id_pay;
	ex_pay_t ex_pay;
	mem_pay_t ex_out;
	mem_pay_t mem_pay;
	wb_pay_t mem_out;
	wb_pay_t wb_pay;
	word_t ex_result;
	word_t mem_wdata;

	assign IM_address = if_pc;

	// decode holds the word fetched one PC earlier, bubbles aside
	assign id_pc = if_pc - pc_t'(1);

	fetch_pc u_fetch_pc (
		.clk(clk),
		.rst_n(rst_n),
		.hazard(hazard),
		.taken(taken),
		.target(br_target),
		.pc(if_pc)
	);

	stage_reg #(.payload_t(instr_t)) u_if_id (
		.clk(clk),
		.rst_n(rst_n),
		.hold(hazard),
		.flush(taken && !hazard),
		.d(instruction),
		.q(id_instr)
	);

	decoder u_decoder (
		.instr(id_instr),
		.pc(id_pc),
		.ra_data(fwd_ra),
		.rt_data(fwd_rt),
		.rb_data(fwd_rb),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ctrl(id_ctrl),
		.imm(op_b),
		.taken(taken),
		.target(br_target)
	);

	regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.ra_data(raw_ra),
		.rb_data(raw_rb),
		.rt_data(raw_rt),
		.we(wb_pay.reg_write),
		.wa(wb_pay.rd),
		.wd(wb_pay.data)
	);

	forward_unit u_forward_unit (
		.ra_addr(ra_addr),
		.rb_addr(rb_addr),
		.rt_addr(rt_addr),
		.raw_ra(raw_ra),
		.raw_rb(raw_rb),
		.raw_rt(raw_rt),
		.ex_pay(ex_pay),
		.ex_result(ex_result),
		.mem_pay(mem_pay),
		.mem_wdata(mem_wdata),
		.wb_pay(wb_pay),
		.fwd_ra(fwd_ra),
		.fwd_rb(fwd_rb),
		.fwd_rt(fwd_rt),
		.hazard(hazard)
	);

	// rt is both the destination and the store source
	assign id_pay = '{ctrl: id_ctrl, a: fwd_ra, b: op_b, st_data: fwd_rt, rd: rt_addr};

	stage_reg #(.payload_t(ex_pay_t)) u_id_ex (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.flush(hazard),
		.d(id_pay),
		.q(ex_pay)
	);

	alu u_alu (
		.op(ex_pay.ctrl.alu_op),
		.a(ex_pay.a),
		.b(ex_pay.b),
		.result(ex_result),
		.overflow(alu_overflow)
	);

	assign ex_out = '{ctrl: ex_pay.ctrl, result: ex_result, st_data: ex_pay.st_data,
		rd: ex_pay.rd};

	stage_reg #(.payload_t(mem_pay_t)) u_ex_mem (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.flush(1'b0),
		.d(ex_out),
		.q(mem_pay)
	);

	assign DM_read = mem_pay.ctrl.mem_read;
	assign DM_write = mem_pay.ctrl.mem_write;
	assign DM_address = mem_pay.result[`DM_AW-1:0];
	assign DM_in = mem_pay.st_data;

	// write-back word, also the memory-stage forward value
	assign mem_wdata = (mem_pay.ctrl.wb_sel == WB_MEM) ? DM_out : mem_pay.result;
	assign mem_out = '{reg_write: mem_pay.ctrl.reg_write, rd: mem_pay.rd, data: mem_wdata};

	stage_reg #(.payload_t(wb_pay_t)) u_mem_wb (
		.clk(clk),
		.rst_n(rst_n),
		.hold(1'b0),
		.flush(1'b0),
		.d(mem_out),
		.q(wb_pay)
	);

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decoder import cpu_pkg::*; (
	input instr_t instr,
	input pc_t pc,
	input word_t ra_data,
	input word_t rt_data,
	input word_t rb_data,
	output reg_addr_t ra_addr,
	output reg_addr_t rb_addr,
	output reg_addr_t rt_addr,
	output ctrl_t ctrl,
	output word_t imm,
	output logic taken,
	output pc_t target
);

	logic [5:0] opcode;
	logic [4:0] sub_op;
	word_t ext_imm;
	word_t imm15_s;
	word_t imm15_z;
	word_t imm20_s;
	word_t br_off;
	word_t j_off;

	assign opcode = instr[30:25];
	assign sub_op = instr[4:0];
	assign rt_addr = instr[24:20];
	assign ra_addr = instr[19:15];
	assign rb_addr = instr[14:10];

	assign imm15_s = {{17{instr[14]}}, instr[14:0]};
	assign imm15_z = {17'b0, instr[14:0]};
	assign imm20_s = {{12{instr[19]}}, instr[19:0]};
	// word offsets
	assign br_off = {{18{instr[13]}}, instr[13:0]};
	assign j_off = {{8{instr[23]}}, instr[23:0]};

	always_comb begin
		ctrl = '0;
		ext_imm = '0;
		taken = 1'b0;
		target = pc + pc_t'(br_off);
		case (opcode)
			`OP_ALU: begin
				ctrl.reg_write = 1'b1;
				case (sub_op)
					`SUB_ADD: ctrl.alu_op = ADD;
					`SUB_SUB: ctrl.alu_op = SUB;
					`SUB_AND: ctrl.alu_op = AND;
					`SUB_OR: ctrl.alu_op = OR;
					`SUB_XOR: ctrl.alu_op = XOR;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				ctrl.alu_op = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ext_imm = imm15_s;
			end
			`OP_ORI: begin
				ctrl.alu_op = OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ext_imm = imm15_z;
			end
			`OP_MOVI: begin
				ctrl.alu_op = PASS_B;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ext_imm = imm20_s;
			end
			`OP_LWI: begin
				ctrl.alu_op = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.wb_sel = WB_MEM;
				ext_imm = {imm15_s[29:0], 2'b00};
			end
			`OP_SWI: begin
				ctrl.alu_op = ADD;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ext_imm = {imm15_s[29:0], 2'b00};
			end
			// bit 14 set is BNE
			`OP_BR: taken = instr[14] ? (rt_data != ra_data) : (rt_data == ra_data);
			`OP_J: begin
				taken = 1'b1;
				target = pc + pc_t'(j_off);
			end
			default: ctrl = '0;
		endcase
	end

	// second operand for execute
	assign imm = ctrl.use_imm ? ext_imm : rb_data;

endmodule

// ==== design/fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic hazard,
	input logic taken,
	input pc_t target,
	output pc_t pc
);

	pc_t pc_next;

	// a stall wins over a redirect, the branch decides again next cycle
	always_comb begin
		if (hazard) begin
			pc_next = pc;
		end else if (taken) begin
			pc_next = target;
		end else begin
			pc_next = pc + pc_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

// ==== design/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit import cpu_pkg::*; (
	input reg_addr_t ra_addr,
	input reg_addr_t rb_addr,
	input reg_addr_t rt_addr,
	input word_t raw_ra,
	input word_t raw_rb,
	input word_t raw_rt,
	input ex_pay_t ex_pay,
	input word_t ex_result,
	input mem_pay_t mem_pay,
	input word_t mem_wdata,
	input wb_pay_t wb_pay,
	output word_t fwd_ra,
	output word_t fwd_rb,
	output word_t fwd_rt,
	output logic hazard
);

	logic ex_hit_ra;
	logic ex_hit_rb;
	logic ex_hit_rt;

	function automatic logic hit(input logic wr, input reg_addr_t rd, input reg_addr_t src);
		return wr && rd == src && src != '0;
	endfunction

	// youngest writer first
	function automatic word_t pick(input reg_addr_t src, input word_t raw,
			input ex_pay_t ex_p, input word_t ex_v, input mem_pay_t mem_p,
			input word_t mem_v, input wb_pay_t wb_p);
		if (hit(ex_p.ctrl.reg_write, ex_p.rd, src)) begin
			return ex_v;
		end
		if (hit(mem_p.ctrl.reg_write, mem_p.rd, src)) begin
			return mem_v;
		end
		if (hit(wb_p.reg_write, wb_p.rd, src)) begin
			return wb_p.data;
		end
		return raw;
	endfunction

	assign fwd_ra = pick(ra_addr, raw_ra, ex_pay, ex_result, mem_pay, mem_wdata, wb_pay);
	assign fwd_rb = pick(rb_addr, raw_rb, ex_pay, ex_result, mem_pay, mem_wdata, wb_pay);
	assign fwd_rt = pick(rt_addr, raw_rt, ex_pay, ex_result, mem_pay, mem_wdata, wb_pay);

	// load data not back yet, any matching field stalls
	assign ex_hit_ra = hit(ex_pay.ctrl.reg_write, ex_pay.rd, ra_addr);
	assign ex_hit_rb = hit(ex_pay.ctrl.reg_write, ex_pay.rd, rb_addr);
	assign ex_hit_rt = hit(ex_pay.ctrl.reg_write, ex_pay.rd, rt_addr);
	assign hazard = ex_pay.ctrl.mem_read && (ex_hit_ra || ex_hit_rb || ex_hit_rt);

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
	input logic clk,
	input logic rst_n,
	input reg_addr_t ra_addr,
	input reg_addr_t rb_addr,
	input reg_addr_t rt_addr,
	output word_t ra_data,
	output word_t rb_data,
	output word_t rt_data,
	input logic we,
	input reg_addr_t wa,
	input word_t wd
);

	word_t regs [32];

	// r0 is never written
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// no write bypass here, forward_unit covers write-back
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

// ==== design/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg import cpu_pkg::*; #(
	parameter type payload_t = word_t
) (
	input logic clk,
	input logic rst_n,
	input logic hold,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// zero payload is a bubble
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cpu -Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0

// ==== tb.f ====
+incdir+common
common/cpu_pkg.sv
design/fetch_pc.sv
design/decoder.sv
design/regfile.sv
design/forward_unit.sv
design/alu.sv
design/stage_reg.sv
design/cpu_top.sv
tb/tb_cpu.sv

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu import cpu_pkg::*; ();

	localparam int PROG_LEN = 47;
	localparam int N_ST = 15;
	localparam int N_LD = 2;
	localparam int MID_ST = 11;
	localparam int EXP_OVF = 2;
	localparam int SETTLE_CYCLES = 20;
	localparam int IM_DEPTH = 1 << `IM_AW;
	localparam int DM_DEPTH = 1 << (`DM_AW - 2);
	localparam int N_PASSES = 3;
	localparam int PASS_CYCLES = PROG_LEN * 4 + 200;
	localparam int WATCHDOG_NS = N_PASSES * PASS_CYCLES * 40;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic in_reset = 1'b0;
	instr_t instruction;
	pc_t im_address;
	logic dm_read;
	logic dm_write;
	logic [`DM_AW-1:0] dm_address;
	word_t dm_in;
	word_t dm_out;
	logic alu_overflow;

	instr_t prog [PROG_LEN];
	instr_t imem [IM_DEPTH];
	word_t dmem [DM_DEPTH];
	int st_idx = 0;
	int ld_idx = 0;
	int ovf_count = 0;
	logic quiet = 1'b0;

	// stores in program order without the sentinels
	logic [`DM_AW-1:0] exp_addr [N_ST] = '{
		12'h100, 12'h104, 12'h108, 12'h10c, 12'h110, 12'h114, 12'h118, 12'h11c,
		12'h120, 12'h124, 12'h128, 12'h12c, 12'h130, 12'h134, 12'h138
	};
	word_t exp_data [N_ST] = '{
		32'h0002_1435, 32'h0000_3255, 32'h0000_2040, 32'h0001_f3f5, 32'h0001_d3b5,
		32'h0001_2340, 32'h0000_f0f1, 32'h0000_0222, 32'h0000_0222, 32'h0000_099f,
		32'h0000_5b6b, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0222, 32'h0000_007e
	};
	// loads in program order
	logic [`DM_AW-1:0] exp_ld_addr [N_LD] = '{12'h004, 12'h000};

	always #20 clk = ~clk;

	// memories answer in the same cycle
	assign instruction = imem[im_address];
	assign dm_out = dmem[dm_address[`DM_AW-1:2]];

	cpu_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instruction(instruction),
		.IM_address(im_address),
		.DM_read(dm_read),
		.DM_write(dm_write),
		.DM_address(dm_address),
		.DM_in(dm_in),
		.DM_out(dm_out),
		.alu_overflow(alu_overflow)
	);

	function automatic instr_t alu_instr(input logic [4:0] sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb);
		return {1'b0, `OP_ALU, rt, ra, rb, 5'b00000, sub};
	endfunction

	function automatic instr_t imm_instr(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic instr_t movi_instr(input reg_addr_t rt, input logic [19:0] imm);
		return {1'b0, `OP_MOVI, rt, imm};
	endfunction

	// word offset from the branch itself
	function automatic instr_t branch_instr(input logic bne, input reg_addr_t rt,
			input reg_addr_t ra, input logic [13:0] off);
		return {1'b0, `OP_BR, rt, ra, bne, off};
	endfunction

	function automatic instr_t jump_instr(input logic [23:0] off);
		return {1'b0, `OP_J, 1'b0, off};
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input string name, input logic [`DM_AW-1:0] got,
			input logic [`DM_AW-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic assemble_program();
		prog[0] = movi_instr(5'd1, 20'h12345);
		prog[1] = movi_instr(5'd2, 20'h0f0f0);
		prog[2] = movi_instr(5'd10, 20'h00100);
		prog[3] = alu_instr(`SUB_ADD, 5'd3, 5'd1, 5'd2);
		prog[4] = imm_instr(`OP_SWI, 5'd3, 5'd10, 15'd0);
		prog[5] = alu_instr(`SUB_SUB, 5'd4, 5'd1, 5'd2);
		prog[6] = imm_instr(`OP_SWI, 5'd4, 5'd10, 15'd1);
		prog[7] = alu_instr(`SUB_AND, 5'd5, 5'd1, 5'd2);
		prog[8] = imm_instr(`OP_SWI, 5'd5, 5'd10, 15'd2);
		prog[9] = alu_instr(`SUB_OR, 5'd6, 5'd1, 5'd2);
		prog[10] = imm_instr(`OP_SWI, 5'd6, 5'd10, 15'd3);
		prog[11] = alu_instr(`SUB_XOR, 5'd7, 5'd1, 5'd2);
		prog[12] = imm_instr(`OP_SWI, 5'd7, 5'd10, 15'd4);
		// -5 then a zero-extended immediate with bit 14 set
		prog[13] = imm_instr(`OP_ADDI, 5'd8, 5'd1, 15'h7ffb);
		prog[14] = imm_instr(`OP_ORI, 5'd9, 5'd2, 15'h4001);
		prog[15] = imm_instr(`OP_SWI, 5'd8, 5'd10, 15'd5);
		prog[16] = imm_instr(`OP_SWI, 5'd9, 5'd10, 15'd6);
		// forwarding at distance 1, 2 and 3
		prog[17] = movi_instr(5'd11, 20'h00111);
		prog[18] = alu_instr(`SUB_ADD, 5'd12, 5'd11, 5'd11);
		prog[19] = imm_instr(`OP_SWI, 5'd12, 5'd10, 15'd7);
		prog[20] = movi_instr(5'd13, 20'h00333);
		prog[21] = imm_instr(`OP_ADDI, 5'd20, 5'd0, 15'd1);
		prog[22] = alu_instr(`SUB_XOR, 5'd14, 5'd13, 5'd11);
		prog[23] = imm_instr(`OP_SWI, 5'd14, 5'd10, 15'd8);
		prog[24] = movi_instr(5'd15, 20'h00ab0);
		prog[25] = imm_instr(`OP_ADDI, 5'd20, 5'd0, 15'd1);
		prog[26] = imm_instr(`OP_ADDI, 5'd21, 5'd0, 15'd2);
		prog[27] = alu_instr(`SUB_SUB, 5'd17, 5'd15, 5'd11);
		prog[28] = imm_instr(`OP_SWI, 5'd17, 5'd10, 15'd9);
		// load then direct use
		prog[29] = imm_instr(`OP_LWI, 5'd18, 5'd0, 15'd1);
		prog[30] = alu_instr(`SUB_ADD, 5'd19, 5'd18, 5'd11);
		prog[31] = imm_instr(`OP_SWI, 5'd19, 5'd10, 15'd10);
		prog[32] = imm_instr(`OP_LWI, 5'd22, 5'd0, 15'd0);
		prog[33] = imm_instr(`OP_ADDI, 5'd23, 5'd0, 15'd1);
		prog[34] = alu_instr(`SUB_ADD, 5'd24, 5'd22, 5'd23);
		prog[35] = alu_instr(`SUB_SUB, 5'd25, 5'd24, 5'd23);
		prog[36] = imm_instr(`OP_SWI, 5'd24, 5'd10, 15'd11);
		prog[37] = imm_instr(`OP_SWI, 5'd25, 5'd10, 15'd12);
		// taken beq, untaken bne and a jump each pass a sentinel store
		prog[38] = branch_instr(1'b0, 5'd12, 5'd14, 14'd2);
		prog[39] = imm_instr(`OP_SWI, 5'd1, 5'd10, 15'd31);
		prog[40] = branch_instr(1'b1, 5'd12, 5'd14, 14'd3);
		prog[41] = imm_instr(`OP_SWI, 5'd12, 5'd10, 15'd13);
		prog[42] = jump_instr(24'd2);
		prog[43] = imm_instr(`OP_SWI, 5'd2, 5'd10, 15'd30);
		prog[44] = movi_instr(5'd26, 20'h0007e);
		prog[45] = imm_instr(`OP_SWI, 5'd26, 5'd10, 15'd14);
		prog[46] = jump_instr(24'd0);
	endtask

	task automatic load_program();
		for (int i = 0; i < IM_DEPTH; i++) begin
			if (i < PROG_LEN) begin
				imem[i] = prog[i];
			end else begin
				imem[i] = '0;
			end
		end
	endtask

	task automatic preset_data();
		for (int i = 0; i < DM_DEPTH; i++) begin
			dmem[i] = 32'hda7a_0000 + 32'(i);
		end
		dmem[0] = 32'h7fff_ffff;
		dmem[1] = 32'h0000_5a5a;
	endtask

	// called just after a rising edge
	task automatic apply_reset();
		#1 rst_n = 1'b0;
		@(posedge clk);
		in_reset = 1'b1;
		load_program();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		in_reset = 1'b0;
	endtask

	task automatic finish_pass();
		wait (st_idx == N_ST);
		repeat (SETTLE_CYCLES) @(posedge clk);
		check_count("DM_read cycles", ld_idx, N_LD);
		check_count("alu_overflow cycles", ovf_count, EXP_OVF);
	endtask

	// memory stage monitor and data memory writes
	initial begin
		preset_data();
		forever begin
			@(negedge clk);
			if (in_reset) begin
				if (dm_read !== 1'b0 || dm_write !== 1'b0 || alu_overflow !== 1'b0) begin
					abort_run("A memory strobe or alu_overflow was high while reset was held");
				end
				preset_data();
				st_idx = 0;
				ld_idx = 0;
				ovf_count = 0;
				quiet = 1'b1;
			end else begin
				if (alu_overflow) begin
					ovf_count++;
				end
				if (dm_read) begin
					if (quiet) begin
						abort_run("DM_read went high before the first store after reset");
					end
					if (ld_idx >= N_LD) begin
						abort_run("A load appeared after the expected loads had ended");
					end
					check_addr("DM_address", dm_address, exp_ld_addr[ld_idx]);
					ld_idx++;
				end
				if (dm_write) begin
					if (st_idx >= N_ST) begin
						abort_run("A store appeared after the expected sequence had ended");
					end
					check_addr("DM_address", dm_address, exp_addr[st_idx]);
					check_word("DM_in", dm_in, exp_data[st_idx]);
					dmem[dm_address[`DM_AW-1:2]] = dm_in;
					st_idx++;
					quiet = 1'b0;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the expected stores did not all appear in time");
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		assemble_program();
		apply_reset();
		finish_pass();
		apply_reset();
		// reset again with a load and an overflowing add in flight
		wait (st_idx == MID_ST);
		@(posedge clk);
		apply_reset();
		finish_pass();
		$display("Regression passed");
		$finish;
	end

endmodule
